// ==== Bender.yml ====
package:
  name: utf_codec

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/utf_pkg.sv
      - hw/utf_ctrl_decode.sv
      - hw/utf_char_register.sv
      - hw/utf8_classifier.sv
      - hw/utf_readback.sv
      - hw/utf_codec_top.sv
  - target: test
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/tb_utf_codec.sv

// ==== compile.f ====
+incdir+hw
+incdir+testbench
hw/utf_pkg.sv
hw/utf_ctrl_decode.sv
hw/utf_char_register.sv
hw/utf8_classifier.sv
hw/utf_readback.sv
hw/utf_codec_top.sv
testbench/tb_utf_codec.sv

// ==== hw/utf8_classifier.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational classification of the character word: UTF-8 length and
// the ready / invalid / overlong / non-Unicode / error status flags.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "utf_cfg.svh"

module utf8_classifier (
    input  utf_pkg::char_state_t state,
    input  utf_pkg::ctrl_t       ctrl,
    output utf_pkg::status_t     status
);

    // Flag sets as {ready, invalid, overlong, nonuni}
    localparam logic [3:0] ST_READY  = 4'b1000;
    localparam logic [3:0] ST_NONUNI = 4'b1001;
    localparam logic [3:0] ST_INVAL  = 4'b1100;
    localparam logic [3:0] ST_OVER   = 4'b1010;
    localparam logic [3:0] ST_UNDER  = 4'b0000;  // Partial UTF-8 input

    logic [31:0] rc;
    logic [2:0]  len;
    logic [3:0]  flags;

    assign rc = state.word.value;

    // Negative partial words count like the bytes already written
    always_comb begin
        if (state.empty)                                     len = 3'd0;
        else if (rc < 32'h0000_0080 || rc >= 32'hFFFF_FF80) len = 3'd1;
        else if (rc < 32'h0000_0800 || rc >= 32'hFFFF_F000) len = 3'd2;
        else if (rc < 32'h0001_0000 || rc >= 32'hFFFE_0000) len = 3'd3;
        else if (rc < 32'h0020_0000 || rc >= 32'hFFC0_0000) len = 3'd4;
        else if (rc < 32'h0400_0000 || rc >= 32'hF800_0000) len = 3'd5;
        else if (rc < 32'h8000_0000 || rc >= 32'hF000_0000) len = 3'd6;
        else                                                 len = 3'd0;
    end

    always_comb begin
        if (state.empty)                    flags = ST_UNDER;
        else if (rc <= `UTF_MAX_UNICODE)    flags = ST_READY;
        else if (rc < 32'h8000_0000)        flags = ST_NONUNI;
        else if (rc < 32'hF000_0000)        flags = ST_INVAL;
        else if (rc < 32'hF400_0000)        flags = ST_OVER;   // 6 bytes
        else if (rc < 32'hF800_0000)        flags = ST_INVAL;
        else if (rc < 32'hF820_0000)        flags = ST_OVER;   // 5 bytes
        else if (rc < 32'hFC00_0000)        flags = ST_INVAL;
        else if (rc < 32'hFE00_0000)        flags = ST_UNDER;  // 5 of 6 bytes
        else if (rc < 32'hFFC0_0000)        flags = ST_INVAL;
        else if (rc < 32'hFFC1_0000)        flags = ST_OVER;   // 4 bytes
        else if (rc < 32'hFFE0_0000)        flags = ST_INVAL;
        else if (rc < 32'hFFF8_0000)        flags = ST_UNDER;
        else if (rc < 32'hFFFE_0000)        flags = ST_INVAL;
        else if (rc < 32'hFFFE_0800)        flags = ST_OVER;   // 3 bytes
        else if (rc < 32'hFFFF_0000)        flags = ST_INVAL;
        else if (rc < 32'hFFFF_E000)        flags = ST_UNDER;
        else if (rc < 32'hFFFF_F000)        flags = ST_INVAL;
        else if (rc < 32'hFFFF_F080)        flags = ST_OVER;   // 2 bytes
        else if (rc < 32'hFFFF_F800)        flags = ST_INVAL;
        else if (rc < 32'hFFFF_FF80)        flags = ST_UNDER;
        else if (rc < 32'hFFFF_FFC0)        flags = ST_INVAL;  // Lone continuation
        else if (rc < 32'hFFFF_FFFE)        flags = ST_UNDER;  // Bare lead byte
        else                                flags = ST_INVAL;  // 0xFE, 0xFF
    end

    assign status.ready        = flags[3];
    assign status.invalid      = flags[2];
    assign status.overlong     = flags[1];
    assign status.nonuni       = flags[0];
    assign status.error        = state.retry | flags[2] | flags[1]
                                 | (flags[0] & ctrl.check_range);
    assign status.utf8_len     = len;
    assign status.utf8_in_full = (len >= `UTF_UTF8_MAX_LEN);

endmodule

// ==== hw/utf_cfg.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map, reset value and code point limits of the UTF codec.
// Included by every block that decodes addresses or checks lengths.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef UTF_CFG_SVH
`define UTF_CFG_SVH

// Bus addresses
`define UTF_ADDR_CTRL        4'd0   // Control write, status read
`define UTF_ADDR_UTF8        4'd1
`define UTF_ADDR_UTF32       4'd3
`define UTF_ADDR_CTRL_RD     4'd4
`define UTF_ADDR_LEN         4'd5

// Control readback after reset: BY_ADDRESS, read, big endian, range check
`define UTF_CTRL_RESET_VALUE 8'hFD

// Highest Unicode code point
`define UTF_MAX_UNICODE      32'h0010_FFFF

// Input and output lengths
`define UTF_UTF32_BYTES      3'd4
`define UTF_UTF8_MAX_LEN     3'd6   // Lead byte 0xFC/0xFD and five continuations

`endif

// ==== hw/utf_char_register.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-bit character register. Assembles UTF-32 bytes in either byte order
// or UTF-8 bytes, collapsing a complete UTF-8 sequence to its code point.
// Partial UTF-8 input is held as a negative word.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "utf_cfg.svh"

module utf_char_register (
    input  logic                 clk,
    input  logic                 rst_n,
    input  utf_pkg::ctrl_t       ctrl,
    input  utf_pkg::access_t     access,
    input  utf_pkg::status_t     status,
    input  logic [7:0]           data_in,
    output utf_pkg::char_state_t state
);

    // Append one continuation byte to a partial word of length len (1 to 5)
    function automatic logic [31:0] utf8_append(
        input logic [31:0] word,
        input logic [2:0]  len,
        input logic [5:0]  bits
    );
        logic [31:0] low_mask;
        logic [31:0] payload;
        logic        complete;
        int          pos;

        pos      = 5 * len;  // Position of the lead's zero marker bit
        low_mask = (32'd1 << pos) - 32'd1;
        // Top code point bits that rule out an overlong form
        if (len == 3'd1) begin
            payload = (word >> 1) & 32'hF;  // Lead bits 4:1 of a 2-byte form
        end else begin
            payload = (word >> (pos - 5)) & 32'h1F;  // Lead payload and first continuation
        end
        // Ones above the marker, marker clear, non-overlong payload
        complete = ((word | ((32'd2 << pos) - 32'd1)) == 32'hFFFF_FFFF)
                   && !word[pos]
                   && (payload != 32'd0);
        if (complete) begin
            return ((word & low_mask) << 6) | {26'b0, bits};
        end else if (len == 3'd5) begin
            return {4'hF, word[21:0], bits};  // Keeps the word negative
        end
        return {word[25:0], bits};
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || access.clear_all) begin
            state.word.value  <= '0;
            state.empty       <= 1'b1;
            state.utf32_count <= '0;
            state.retry       <= 1'b0;
        end else if (access.utf32_write) begin
            if (state.utf32_count == 3'd0) begin
                state.word.value  <= {24'b0, data_in};  // First byte zero-extended
                state.empty       <= 1'b0;
                state.utf32_count <= 3'd1;
            end else if (state.utf32_count >= `UTF_UTF32_BYTES) begin
                state.retry <= 1'b1;
            end else begin
                if (ctrl.big_endian) begin
                    state.word.value <= {state.word.value[23:0], data_in};
                end else begin
                    state.word.bytes[state.utf32_count[1:0]] <= data_in;
                end
                state.utf32_count <= state.utf32_count + 3'd1;
            end
        end else if (access.utf8_write) begin
            if (status.utf8_len == 3'd0) begin
                // Lead byte sign-extended so partial words sort high
                state.word.value <= {{24{data_in[7]}}, data_in};
                state.empty      <= 1'b0;
            end else if (status.ready || (data_in[7:6] != 2'b10)) begin
                state.retry <= 1'b1;  // Character done or not a continuation
            end else begin
                state.word.value <= utf8_append(state.word.value, status.utf8_len,
                                                data_in[5:0]);
            end
        end
    end

endmodule

// ==== hw/utf_codec_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte-wide UTF-8 / UTF-32 converter peripheral. A character is written
// in one encoding and read back a byte at a time in either encoding.
// Writes use a plain strobe; data_out is combinational from the address.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module utf_codec_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] address,
    input  logic       data_write,
    input  logic [7:0] data_in,
    output logic [7:0] data_out
);

    utf_pkg::ctrl_t       ctrl;
    utf_pkg::access_t     access;
    utf_pkg::read_sel_e   read_sel;
    utf_pkg::char_state_t state;
    utf_pkg::status_t     status;

    utf_ctrl_decode u_ctrl_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data_write (data_write),
        .data_in    (data_in),
        .ctrl       (ctrl),
        .access     (access),
        .read_sel   (read_sel)
    );

    utf_char_register u_char_register (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .access  (access),
        .status  (status),
        .data_in (data_in),
        .state   (state)
    );

    utf8_classifier u_classifier (
        .state  (state),
        .ctrl   (ctrl),
        .status (status)
    );

    utf_readback u_readback (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .access   (access),
        .state    (state),
        .status   (status),
        .read_sel (read_sel),
        .data_out (data_out)
    );

endmodule

// ==== hw/utf_ctrl_decode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control register and bus decode. Turns each write into one set of
// single-cycle access strobes and picks the readback source by address.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "utf_cfg.svh"

module utf_ctrl_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [3:0]         address,
    input  logic               data_write,
    input  logic [7:0]         data_in,
    output utf_pkg::ctrl_t     ctrl,
    output utf_pkg::access_t   access,
    output utf_pkg::read_sel_e read_sel
);

    localparam logic [7:0] CTRL_RESET = `UTF_CTRL_RESET_VALUE;

    logic data_addr;  // One of the data addresses, 1 to 3
    logic ctrl_hit;
    logic data_hit;
    logic sel_utf8;
    logic sel_utf32;

    assign data_addr = (address >= `UTF_ADDR_UTF8) && (address <= `UTF_ADDR_UTF32);
    assign ctrl_hit  = data_write && (address == `UTF_ADDR_CTRL);
    assign data_hit  = data_write && data_addr;

    always_comb begin
        sel_utf8  = 1'b0;
        sel_utf32 = 1'b0;
        case (ctrl.mode)
            utf_pkg::UTF8:       sel_utf8  = 1'b1;
            utf_pkg::UTF32:      sel_utf32 = 1'b1;
            utf_pkg::BY_ADDRESS: begin
                sel_utf8  = (address == `UTF_ADDR_UTF8);
                sel_utf32 = (address == `UTF_ADDR_UTF32);  // Address 2 selects nothing
            end
            default: ;  // UNUSED drops data accesses
        endcase
    end

    assign access.ctrl_write  = ctrl_hit;
    assign access.clear_all   = ctrl_hit && !data_in[7];
    assign access.rewind      = ctrl_hit && data_in[7] && !data_in[0];  // Clear covers rewind
    assign access.utf8_write  = data_hit && sel_utf8 && !ctrl.read;
    assign access.utf8_read   = data_hit && sel_utf8 && ctrl.read;
    assign access.utf32_write = data_hit && sel_utf32 && !ctrl.read;
    assign access.utf32_read  = data_hit && sel_utf32 && ctrl.read;

    // Control byte bits 6:2 map straight onto ctrl_t
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl <= utf_pkg::ctrl_t'(CTRL_RESET[6:2]);
        end else if (ctrl_hit) begin
            ctrl <= utf_pkg::ctrl_t'(data_in[6:2]);
        end
    end

    always_comb begin
        read_sel = utf_pkg::NONE;  // Unmapped addresses read 0
        if (address == `UTF_ADDR_CTRL) begin
            read_sel = utf_pkg::STATUS;
        end else if (data_addr) begin
            read_sel = utf_pkg::DOUT;
        end else if (address == `UTF_ADDR_CTRL_RD) begin
            read_sel = utf_pkg::CTRL;
        end else if (address == `UTF_ADDR_LEN) begin
            read_sel = utf_pkg::LEN;
        end
    end

endmodule

// ==== hw/utf_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the UTF codec: control fields, access strobes, the
// character word and the status bundle passed between the blocks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package utf_pkg;

    typedef enum logic [1:0] {
        UTF8       = 2'b00,
        UNUSED     = 2'b01,  // No data access
        UTF32      = 2'b10,
        BY_ADDRESS = 2'b11   // Encoding follows the data address
    } utf_mode_e;

    // Same order as control byte bits 6:2
    typedef struct packed {
        utf_mode_e mode;
        logic      read;
        logic      big_endian;
        logic      check_range;
    } ctrl_t;

    typedef struct packed {
        logic ctrl_write;
        logic clear_all;
        logic rewind;
        logic utf8_write;
        logic utf8_read;
        logic utf32_write;
        logic utf32_read;
    } access_t;

    typedef enum logic [2:0] {STATUS, DOUT, CTRL, LEN, NONE} read_sel_e;

    typedef union packed {
        logic [31:0]     value;
        logic [3:0][7:0] bytes;  // Byte 0 is least significant
    } char_word_u;

    typedef struct packed {
        char_word_u word;
        logic       empty;
        logic [2:0] utf32_count;  // UTF-32 bytes written so far
        logic       retry;
    } char_state_t;

    typedef struct packed {
        logic       ready;
        logic       invalid;
        logic       overlong;
        logic       nonuni;
        logic       error;
        logic [2:0] utf8_len;
        logic       utf8_in_full;
    } status_t;

endpackage

// ==== hw/utf_readback.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read side of the codec. Read strobes step the UTF-8 or UTF-32 pointer
// and latch the next byte; data_out muxes status, control, lengths or
// the latched byte by address with no clock delay.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "utf_cfg.svh"

module utf_readback (
    input  logic                 clk,
    input  logic                 rst_n,
    input  utf_pkg::ctrl_t       ctrl,
    input  utf_pkg::access_t     access,
    input  utf_pkg::char_state_t state,
    input  utf_pkg::status_t     status,
    input  utf_pkg::read_sel_e   read_sel,
    output logic [7:0]           data_out
);

    logic [31:0] rc;
    logic [2:0]  len;
    logic [2:0]  utf8_ptr;
    logic [2:0]  utf32_ptr;
    logic [7:0]  dout;        // Latched output byte
    logic [7:0]  utf8_byte;   // Byte at utf8_ptr
    logic [7:0]  utf32_byte;  // Byte at utf32_ptr
    logic        eof;

    assign rc  = state.word.value;
    assign len = status.utf8_len;

    always_comb begin
        utf8_byte = 8'h00;  // Past the end
        if (utf8_ptr < len) begin
            if (utf8_ptr == 3'd0) begin
                case (len)
                    3'd1:    utf8_byte = rc[7:0];
                    3'd2:    utf8_byte = {2'b11, rc[11:6]};
                    3'd3:    utf8_byte = {3'b111, rc[16:12]};
                    3'd4:    utf8_byte = {4'b1111, rc[21:18]};
                    3'd5:    utf8_byte = {5'b11111, rc[26:24]};
                    default: utf8_byte = {7'b1111110, rc[31] ? 1'b0 : rc[30]};
                endcase
            end else begin
                case (len - utf8_ptr)  // Continuations left to send
                    3'd1:    utf8_byte = {2'b10, rc[5:0]};
                    3'd2:    utf8_byte = {2'b10, rc[11:6]};
                    3'd3:    utf8_byte = {2'b10, rc[17:12]};
                    3'd4:    utf8_byte = {2'b10, rc[23:18]};
                    default: utf8_byte = {2'b10, rc[31] ? 2'b00 : rc[29:28], rc[27:24]};
                endcase
            end
        end
    end

    always_comb begin
        utf32_byte = 8'h00;
        if (utf32_ptr < `UTF_UTF32_BYTES) begin
            if (ctrl.big_endian) begin
                utf32_byte = state.word.bytes[2'd3 - utf32_ptr[1:0]];
            end else begin
                utf32_byte = state.word.bytes[utf32_ptr[1:0]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || access.clear_all || access.rewind) begin
            utf8_ptr  <= '0;
            utf32_ptr <= '0;
            dout      <= '0;
        end else if (access.utf8_read) begin
            dout <= utf8_byte;
            if (utf8_ptr < len) utf8_ptr <= utf8_ptr + 3'd1;
        end else if (access.utf32_read) begin
            dout <= utf32_byte;
            if (utf32_ptr < `UTF_UTF32_BYTES) utf32_ptr <= utf32_ptr + 3'd1;
        end
    end

    // Nothing to report for an empty character
    assign eof = !state.empty && (ctrl.read ? (utf8_ptr >= len) : status.utf8_in_full);

    always_comb begin
        case (read_sel)
            utf_pkg::STATUS: data_out = {eof, 1'b0, status.error, status.nonuni,
                                         status.overlong, status.invalid,
                                         state.retry, status.ready};
            utf_pkg::DOUT:   data_out = dout;
            utf_pkg::CTRL:   data_out = {1'b1, ctrl.mode, ctrl.read, ctrl.big_endian,
                                         ctrl.check_range, 1'b0, 1'b1};
            utf_pkg::LEN:    data_out = {1'b0, state.utf32_count, 1'b0, len};
            default:         data_out = 8'h00;
        endcase
    end

endmodule

// ==== testbench/tb_utf_tasks.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus tasks, compare tasks and directed tests of the codec testbench.
// Included inside the testbench module body.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_UTF_TASKS_SVH
`define TB_UTF_TASKS_SVH

// One write strobe, driven on the falling edge; ends on a falling edge
task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
    @(negedge clk);
    address    = addr;
    data_in    = data;
    data_write = 1'b1;
    @(negedge clk);
    data_write = 1'b0;
endtask

task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
    @(negedge clk);
    address    = addr;
    data_write = 1'b0;
    @(negedge clk);
    data = data_out;
endtask

function automatic logic [7:0] make_ctrl(input logic keep, input utf_pkg::utf_mode_e mode,
                                         input logic rd, input logic be,
                                         input logic chk, input logic keep_ptr);
    return {keep, mode, rd, be, chk, 1'b0, keep_ptr};
endfunction

function automatic utf_pkg::status_t make_status(input logic rdy, input logic inv,
                                                 input logic ovl, input logic nonu,
                                                 input logic err);
    utf_pkg::status_t s;
    s              = '0;
    s.ready        = rdy;
    s.invalid      = inv;
    s.overlong     = ovl;
    s.nonuni       = nonu;
    s.error        = err;
    return s;
endfunction

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
        $display("FAILED %s: expected 0x%02h, got 0x%02h", name, exp, got);
        error_count++;
    end
endtask

// Status byte minus its eof bit
task automatic check_status(input utf_pkg::status_t exp, input logic exp_retry);
    logic [7:0] got;
    logic [6:0] want;
    bus_read(`UTF_ADDR_CTRL, got);
    want = {1'b0, exp.error, exp.nonuni, exp.overlong, exp.invalid, exp_retry, exp.ready};
    check_count++;
    if (got[6:0] !== want) begin
        $display("FAILED status: expected 0x%02h, got 0x%02h", want, got[6:0]);
        error_count++;
    end
endtask

task automatic check_ctrl(input utf_pkg::ctrl_t exp);
    logic [7:0] got;
    bus_read(`UTF_ADDR_CTRL_RD, got);
    check_byte("ctrl", got, {1'b1, exp, 2'b01});
endtask

task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
        $display("%s: ok", name);
    end else begin
        failed_tests++;
        $display("%s: %0d mismatches", name, error_count - errors_before);
    end
endtask

task automatic reset_values_test();
    int             e0;
    logic [7:0]     got;
    utf_pkg::ctrl_t exp_ctrl;
    e0 = error_count;
    exp_ctrl.mode        = utf_pkg::BY_ADDRESS;
    exp_ctrl.read        = 1'b1;
    exp_ctrl.big_endian  = 1'b1;
    exp_ctrl.check_range = 1'b1;
    check_ctrl(exp_ctrl);
    bus_read(`UTF_ADDR_CTRL, got);
    check_byte("status", got, 8'h00);
    report_test("reset values", e0);
endtask

task automatic utf32_to_utf8_test();
    int          e0;
    int          n;
    logic [31:0] cp;
    logic [7:0]  got;
    e0 = error_count;
    for (int c = 0; c < CHAR_COUNT; c++) begin
        cp = random_code_point();
        n  = ref_len(cp);
        bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b0, utf_pkg::UTF32, 1'b0, 1'b1, 1'b1, 1'b1));
        for (int i = 3; i >= 0; i--) bus_write(`UTF_ADDR_UTF32, cp[8*i +: 8]);
        bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b1, utf_pkg::UTF8, 1'b1, 1'b1, 1'b1, 1'b0));
        for (int i = 0; i <= n; i++) begin
            bus_write(`UTF_ADDR_UTF8, 8'h00);
            check_byte("data_out", data_out, (i < n) ? ref_byte(cp, i) : 8'h00);
        end
        bus_read(`UTF_ADDR_CTRL, got);
        check_byte("status", got, 8'h81);  // Read pointer at length, ready
        bus_read(`UTF_ADDR_LEN, got);
        check_byte("len", got, {1'b0, 3'd4, 1'b0, n[2:0]});
    end
    report_test("utf32 to utf8", e0);
endtask

task automatic utf8_to_utf32_test();
    int          e0;
    logic [31:0] cp;
    e0 = error_count;
    for (int c = 0; c < CHAR_COUNT; c++) begin
        cp = random_code_point();
        bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b0, utf_pkg::UTF8, 1'b0, 1'b1, 1'b1, 1'b1));
        for (int i = 0; i < ref_len(cp); i++) bus_write(`UTF_ADDR_UTF8, ref_byte(cp, i));
        check_status(make_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
        bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b1, utf_pkg::UTF32, 1'b1, 1'b0, 1'b1, 1'b0));
        for (int i = 0; i < 4; i++) begin
            bus_write(`UTF_ADDR_UTF32, 8'h00);
            check_byte("data_out", data_out, cp[8*i +: 8]);  // Little endian
        end
    end
    report_test("utf8 to utf32", e0);
endtask

task automatic overlong_retry_test();
    int         e0;
    logic [7:0] got;
    e0 = error_count;
    bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b0, utf_pkg::UTF8, 1'b0, 1'b1, 1'b1, 1'b1));
    bus_write(`UTF_ADDR_UTF8, 8'hC0);
    bus_write(`UTF_ADDR_UTF8, 8'h80);
    check_status(make_status(1'b1, 1'b0, 1'b1, 1'b0, 1'b1), 1'b0);
    bus_write(`UTF_ADDR_UTF8, 8'h80);  // Character already complete
    check_status(make_status(1'b1, 1'b0, 1'b1, 1'b0, 1'b1), 1'b1);
    bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b0, utf_pkg::UTF32, 1'b0, 1'b1, 1'b1, 1'b1));
    bus_read(`UTF_ADDR_CTRL, got);
    check_byte("status", got, 8'h00);
    for (int i = 0; i < 4; i++) bus_write(`UTF_ADDR_UTF32, (i == 3) ? 8'h41 : 8'h00);
    check_status(make_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
    bus_write(`UTF_ADDR_UTF32, 8'h42);
    check_status(make_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b1), 1'b1);
    bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b0, utf_pkg::UTF32, 1'b0, 1'b1, 1'b1, 1'b1));
    bus_read(`UTF_ADDR_CTRL, got);
    check_byte("status", got, 8'h00);
    report_test("overlong and retry", e0);
endtask

task automatic range_check_test();
    int e0;
    e0 = error_count;
    bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b0, utf_pkg::UTF32, 1'b0, 1'b1, 1'b1, 1'b1));
    bus_write(`UTF_ADDR_UTF32, 8'h00);
    bus_write(`UTF_ADDR_UTF32, 8'h20);
    bus_write(`UTF_ADDR_UTF32, 8'h00);
    bus_write(`UTF_ADDR_UTF32, 8'h00);
    check_status(make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b1), 1'b0);
    // Range check off, character kept
    bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b1, utf_pkg::UTF32, 1'b0, 1'b1, 1'b0, 1'b1));
    check_status(make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b0), 1'b0);
    report_test("range check", e0);
endtask

task automatic by_address_test();
    int          e0;
    logic [31:0] cp;
    logic [7:0]  got;
    e0 = error_count;
    cp = 32'h0000_20AC;
    bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b0, utf_pkg::BY_ADDRESS, 1'b0, 1'b1, 1'b1, 1'b1));
    for (int i = 0; i < ref_len(cp); i++) bus_write(`UTF_ADDR_UTF8, ref_byte(cp, i));
    check_status(make_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
    bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b1, utf_pkg::BY_ADDRESS, 1'b1, 1'b1, 1'b1, 1'b0));
    for (int i = 3; i >= 0; i--) begin
        bus_write(`UTF_ADDR_UTF32, 8'h00);
        check_byte("data_out", data_out, cp[8*i +: 8]);  // Big endian
    end
    bus_write(`UTF_ADDR_CTRL, make_ctrl(1'b0, utf_pkg::UNUSED, 1'b0, 1'b1, 1'b1, 1'b1));
    bus_write(`UTF_ADDR_UTF8, 8'h41);
    bus_write(`UTF_ADDR_UTF32, 8'h42);
    bus_read(`UTF_ADDR_CTRL, got);
    check_byte("status", got, 8'h00);
    report_test("by address", e0);
endtask

`endif

// ==== testbench/tb_utf_codec.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the UTF-8 / UTF-32 codec. Runs directed tests through the
// byte bus with LFSR code points and a reference UTF-8 encoder.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "utf_cfg.svh"

module tb_utf_codec;

    localparam int CHAR_COUNT  = 8;   // Random characters per conversion test
    // Bus operations per test, about two cycles each
    localparam int TEST_OPS    = 5 + 2 * (CHAR_COUNT * 16) + 20 + 10 + 20;
    localparam int TEST_CYCLES = 4 + 2 * TEST_OPS;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic       clk;
    logic       rst_n;
    logic [3:0] address;
    logic       data_write;
    logic [7:0] data_in;
    logic [7:0] data_out;

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          error_count;
    int          check_count;
    int          test_count;
    int          failed_tests;

    utf_codec_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data_write (data_write),
        .data_in    (data_in),
        .data_out   (data_out)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return r;
    endfunction

    // Spread over the four UTF-8 lengths
    function automatic logic [31:0] random_code_point();
        logic [31:0] cls;
        cls = rand_bits(2);
        case (cls[1:0])
            2'd0:    return rand_bits(7);
            2'd1:    return rand_bits(11);
            2'd2:    return rand_bits(16);
            default: return rand_bits(21) % 32'h0011_0000;
        endcase
    endfunction

    // Standard UTF-8 encoding
    function automatic int ref_len(input logic [31:0] cp);
        if (cp < 32'h80) return 1;
        if (cp < 32'h800) return 2;
        if (cp < 32'h1_0000) return 3;
        return 4;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] cp, input int idx);
        int          n;
        logic [31:0] sh;
        n = ref_len(cp);
        if (idx > 0) begin
            sh = cp >> (6 * (n - 1 - idx));
            return {2'b10, sh[5:0]};
        end
        case (n)
            1:       return cp[7:0];
            2:       return {3'b110, cp[10:6]};
            3:       return {4'b1110, cp[15:12]};
            default: return {5'b11110, cp[20:18]};
        endcase
    endfunction

    `include "tb_utf_tasks.svh"

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        address      = '0;
        data_write   = 1'b0;
        data_in      = '0;
        lfsr_state   = 32'h9c7a_a0e4;
        cycle_count  = 0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        reset_values_test();
        utf32_to_utf8_test();
        utf8_to_utf32_test();
        overlong_retry_test();
        range_check_test();
        by_address_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
